// File: common/wide_accum_macros.svh
`ifndef WIDE_ACCUM_MACROS_SVH
`define WIDE_ACCUM_MACROS_SVH

////////////////////////////////////////
// Operand and result widths
////////////////////////////////////////

// Width of the z operand
`define ACC_Z_W      41

// Width of p and acc_init, a whole number of slices above ACC_Z_W
`define ACC_P_W      96

////////////////////////////////////////
// Slice geometry
////////////////////////////////////////

// One adder slice of the chain
`define ACC_SLICE_W  48

// Slices needed to cover the accumulator
`define ACC_SLICES   (`ACC_P_W / `ACC_SLICE_W)

`endif

// File: common/wide_accum_pkg.sv
`include "wide_accum_macros.svh"

package wide_accum_pkg;

    ////////////////////////////////////////
    // Slice data
    ////////////////////////////////////////

    // One word of the carry chain, slice 0 holds the lowest bits of p
    typedef logic [`ACC_SLICE_W-1:0] slice_t;

    ////////////////////////////////////////
    // Accumulate operation
    ////////////////////////////////////////

    // Meaning of acc_addsub
    typedef enum logic
    {
        ACC_ADD = 1'b0,                             // p <= p + z
        ACC_SUB = 1'b1                              // p <= p - z
    } acc_op_e;

endpackage

// File: accum/acc_operand_prep.sv
`timescale 1ns/1ps

`include "wide_accum_macros.svh"

module acc_operand_prep
    import wide_accum_pkg::*;
#(
    parameter int Z_SIGNED = 1                      // 1 treats z as two's complement
)
(
    input  logic [`ACC_Z_W-1:0]      z,
    input  acc_op_e                  acc_addsub,
    output slice_t [`ACC_SLICES-1:0] operand,       // Slice 0 lowest
    output logic                     carry_first    // Carry into slice 0
);

    localparam int EXT_W = `ACC_P_W - `ACC_Z_W;     // Bits added above z

    logic                z_fill;                    // Value of the extension bits
    logic [`ACC_P_W-1:0] z_ext;                     // z at full accumulator width
    logic                do_sub;
    logic [`ACC_P_W-1:0] sub_mask;                  // All ones when subtracting
    logic [`ACC_P_W-1:0] op_full;                   // Operand before slicing

    ////////////////////////////////////////
    // Extension of z
    ////////////////////////////////////////

    // Unsigned z gets zeros, signed z repeats its top bit
    assign z_fill = (Z_SIGNED != 0) ? z[`ACC_Z_W-1] : 1'b0;
    assign z_ext  = {{EXT_W{z_fill}}, z};

    ////////////////////////////////////////
    // Add or subtract
    ////////////////////////////////////////

    // p - z is done as p + ~z + 1 over the whole chain,
    // so the +1 enters once at slice 0 and the inversion covers every slice
    assign do_sub      = (acc_addsub == ACC_SUB);
    assign sub_mask    = {`ACC_P_W{do_sub}};
    assign op_full     = z_ext ^ sub_mask;          // Invert on subtract
    assign carry_first = do_sub;

    ////////////////////////////////////////
    // Split into slice words
    ////////////////////////////////////////

    generate
        for (genvar s = 0; s < `ACC_SLICES; s++)
        begin : g_split
            assign operand[s] = op_full[s*`ACC_SLICE_W +: `ACC_SLICE_W];
        end
    endgenerate

endmodule

// File: accum/acc_slice.sv
`timescale 1ns/1ps

`include "wide_accum_macros.svh"

module acc_slice
    import wide_accum_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   ce,                              // Clock enable for the register
    input  logic   reload,                          // Load init_slice instead of sum
    input  slice_t init_slice,
    input  slice_t operand,                         // Already inverted for subtract
    input  logic   carry_in,
    output logic   carry_out,                       // Combinational, to the slice above
    output slice_t p_slice
);

    slice_t                acc_q;                   // Accumulator register
    logic [`ACC_SLICE_W:0] acc_ext;                 // Register with a zero on top
    logic [`ACC_SLICE_W:0] op_ext;                  // Operand with a zero on top
    logic [`ACC_SLICE_W:0] cin_ext;                 // Carry in at sum width
    logic [`ACC_SLICE_W:0] sum;                     // Carry out in the top bit

    ////////////////////////////////////////
    // Slice adder
    ////////////////////////////////////////

    assign acc_ext = {1'b0, acc_q};
    assign op_ext  = {1'b0, operand};
    assign cin_ext = {{`ACC_SLICE_W{1'b0}}, carry_in};

    assign sum       = acc_ext + op_ext + cin_ext;
    assign carry_out = sum[`ACC_SLICE_W];

    // carry_out is still produced during a reload. The slice above
    // reloads in the same cycle, so it never adds that carry

    ////////////////////////////////////////
    // Accumulator register
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            acc_q <= '0;
        end
        else if (ce)
        begin
            if (reload)
            begin
                acc_q <= init_slice;                // Start a new sum
            end
            else
            begin
                acc_q <= sum[`ACC_SLICE_W-1:0];     // Drop carry, it goes upward
            end
        end
    end

    assign p_slice = acc_q;

endmodule

// File: rtl/wide_accum.sv
`timescale 1ns/1ps

`include "wide_accum_macros.svh"

module wide_accum
    import wide_accum_pkg::*;
#(
    parameter int Z_SIGNED = 1                      // 0 zero-extends z
)
(
    input  logic                clk,
    input  logic                rst,
    input  logic                ce,                 // Cycle is ignored when low
    input  logic [`ACC_Z_W-1:0] z,
    input  logic [`ACC_P_W-1:0] acc_init,
    input  logic                reload,
    input  acc_op_e             acc_addsub,
    output logic [`ACC_P_W-1:0] p
);

    slice_t [`ACC_SLICES-1:0] operand;              // Prepared z per slice
    logic                     carry_first;          // Subtract carry into slice 0
    logic   [`ACC_SLICES:0]   carry;                // Carry chain, one per boundary
    slice_t [`ACC_SLICES-1:0] init_slices;          // acc_init cut into slices
    slice_t [`ACC_SLICES-1:0] p_slices;             // Registered slice outputs

    ////////////////////////////////////////
    // Elaboration checks
    ////////////////////////////////////////

    generate
        if ((`ACC_P_W % `ACC_SLICE_W) != 0)
        begin : g_bad_p_multiple
            $fatal(1, "wide_accum: ACC_P_W %0d is not a multiple of %0d",
                   `ACC_P_W, `ACC_SLICE_W);
        end
        if (`ACC_P_W <= `ACC_Z_W)
        begin : g_bad_p_size
            $fatal(1, "wide_accum: ACC_P_W %0d must exceed ACC_Z_W %0d",
                   `ACC_P_W, `ACC_Z_W);
        end
        if ((Z_SIGNED != 0) && (Z_SIGNED != 1))
        begin : g_bad_z_signed
            $fatal(1, "wide_accum: Z_SIGNED %0d must be 0 or 1", Z_SIGNED);
        end
    endgenerate

    ////////////////////////////////////////
    // Operand preparation
    ////////////////////////////////////////

    acc_operand_prep #(
        .Z_SIGNED    (Z_SIGNED)
    ) u_prep (
        .z           (z),
        .acc_addsub  (acc_addsub),
        .operand     (operand),
        .carry_first (carry_first)
    );

    assign init_slices = acc_init;                  // Slice 0 gets bits 47:0
    assign carry[0]    = carry_first;

    ////////////////////////////////////////
    // Slice chain
    ////////////////////////////////////////

    // The carry ripples through every slice in one cycle.
    // carry[ACC_SLICES] leaves the top slice and is dropped (wraps modulo 2**ACC_P_W)
    generate
        for (genvar s = 0; s < `ACC_SLICES; s++)
        begin : g_slice
            acc_slice u_slice (
                .clk        (clk),
                .rst        (rst),
                .ce         (ce),
                .reload     (reload),
                .init_slice (init_slices[s]),
                .operand    (operand[s]),
                .carry_in   (carry[s]),
                .carry_out  (carry[s+1]),
                .p_slice    (p_slices[s])
            );
        end
    endgenerate

    assign p = p_slices;                            // Slice 0 lowest

endmodule

// File: sim/wide_accum_asserts.sv
`timescale 1ns/1ps

`include "wide_accum_macros.svh"

module wide_accum_asserts
    import wide_accum_pkg::*;
(
    input logic   clk,
    input logic   rst,
    input logic   ce,
    input logic   carry_out,
    input slice_t p_slice
);

    // Register clears on reset
    a_reset_clears: assert property (@(posedge clk) rst |=> (p_slice == '0))
        else $error("slice register not zero after reset");

    // Register holds while ce is low
    a_hold_when_idle: assert property (@(posedge clk) disable iff (rst)
                                       !ce |=> $stable(p_slice))
        else $error("slice register changed with ce low");

    a_carry_known: assert property (@(posedge clk) disable iff (rst)
                                    !$isunknown(carry_out))
        else $error("slice carry_out unknown");

endmodule

bind acc_slice wide_accum_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .ce        (ce),
    .carry_out (carry_out),
    .p_slice   (p_slice)
);

// File: sim/wide_accum_tb.sv
`timescale 1ns/1ps

`include "wide_accum_macros.svh"

module wide_accum_tb
    import wide_accum_pkg::*;
#(
    parameter int Z_SIGNED = 1                      // Passed on to the DUT
);

    localparam int          RESET_TIMEOUT = 20;     // Cycles allowed for p to clear
    localparam int          RANDOM_CYCLES = 2000;
    localparam logic [31:0] SEED          = 32'he07ae44c;

    logic                clk;
    logic                rst;
    logic                ce;
    logic [`ACC_Z_W-1:0] z;
    logic [`ACC_P_W-1:0] acc_init;
    logic                reload;
    acc_op_e             acc_addsub;
    logic [`ACC_P_W-1:0] p;

    logic [`ACC_P_W-1:0] model;                     // Expected value of p
    int                  errors;
    int                  tests_passed;
    int                  tests_failed;
    logic                timed_out;

    wide_accum #(
        .Z_SIGNED   (Z_SIGNED)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .ce         (ce),
        .z          (z),
        .acc_init   (acc_init),
        .reload     (reload),
        .acc_addsub (acc_addsub),
        .p          (p)
    );

    always
    begin
        #20 clk = ~clk;                             // 40 ns period
    end

    ////////////////////////////////////////
    // Model and random values
    ////////////////////////////////////////

    // Value of z at full width
    // A negative z counts as z - 2**ACC_Z_W
    function automatic logic [`ACC_P_W-1:0] extend_z(input logic [`ACC_Z_W-1:0] z_v);
        logic [`ACC_P_W-1:0] v;
        logic [`ACC_P_W-1:0] span;
        v = '0;
        v[`ACC_Z_W-1:0] = z_v;
        span = '0;
        span[`ACC_Z_W] = 1'b1;
        if ((Z_SIGNED != 0) && z_v[`ACC_Z_W-1])
        begin
            v = v - span;
        end
        return v;
    endfunction

    function automatic logic [`ACC_Z_W-1:0] random_z();
        logic [`ACC_Z_W-1:0] v;
        logic [31:0]         r;
        r = '0;
        for (int i = 0; i < `ACC_Z_W; i++)
        begin
            if ((i % 32) == 0)
            begin
                r = $urandom;
            end
            v[i] = r[i % 32];
        end
        return v;
    endfunction

    function automatic logic [`ACC_P_W-1:0] random_p();
        logic [`ACC_P_W-1:0] v;
        logic [31:0]         r;
        for (int i = 0; i < `ACC_P_W; i += 16)
        begin
            r = $urandom;
            v[i +: 16] = r[15:0];
        end
        return v;
    endfunction

    ////////////////////////////////////////
    // Cycle driver and checks
    ////////////////////////////////////////

    task automatic check_value(input logic [`ACC_P_W-1:0] exp, input string what);
        if (p !== exp)
        begin
            $display("error at %0t: %s, p = %h, expected %h", $time, what, p, exp);
            errors++;
        end
    endtask

    // Drives on the falling edge and checks one cycle later
    task automatic apply_cycle(input logic ce_v, input logic reload_v, input acc_op_e op_v,
                               input logic [`ACC_Z_W-1:0] z_v,
                               input logic [`ACC_P_W-1:0] init_v);
        ce         = ce_v;
        reload     = reload_v;
        acc_addsub = op_v;
        z          = z_v;
        acc_init   = init_v;
        if (ce_v)
        begin
            if (reload_v)
            begin
                model = init_v;
            end
            else if (op_v == ACC_SUB)
            begin
                model = model - extend_z(z_v);
            end
            else
            begin
                model = model + extend_z(z_v);
            end
        end
        @(negedge clk);
        check_value(model, "p differs from model");
    endtask

    task automatic finish_test(input string name, input int start_errors);
        if (errors == start_errors)
        begin
            $display("test %s: passed", name);
            tests_passed++;
        end
        else
        begin
            $display("test %s: failed with %0d errors", name, errors - start_errors);
            tests_failed++;
        end
    endtask

    ////////////////////////////////////////
    // Behaviors
    ////////////////////////////////////////

    task automatic reset_and_idle();
        int                  start;
        int                  cyc;
        logic [`ACC_P_W-1:0] init_v;
        start = errors;
        for (cyc = 0; (cyc < RESET_TIMEOUT) && (p !== '0); cyc++)
        begin
            @(negedge clk);
        end
        if (p !== '0)
        begin
            $display("timeout: p did not read zero within %0d cycles after reset",
                     RESET_TIMEOUT);
            timed_out = 1'b1;
            errors++;
        end

        // Nonzero value first, so that the reset has something to clear
        init_v = random_p();
        init_v[`ACC_P_W-1] = 1'b1;
        apply_cycle(1'b1, 1'b1, ACC_ADD, random_z(), init_v);
        rst        = 1'b1;                          // Reset wins over an add with ce high
        ce         = 1'b1;
        reload     = 1'b0;
        acc_addsub = ACC_ADD;
        z          = random_z();
        @(negedge clk);
        rst   = 1'b0;
        model = '0;
        check_value(model, "p not zero after reset");

        for (cyc = 0; cyc < 8; cyc++)                // Other inputs wander with ce low
        begin
            apply_cycle(1'b0, 1'($urandom_range(0, 1)),
                        ($urandom_range(0, 1) == 0) ? ACC_ADD : ACC_SUB,
                        random_z(), random_p());
        end
        finish_test("reset", start);
    endtask

    task automatic reload_values();
        int                  start;
        logic [`ACC_P_W-1:0] init_v;
        start = errors;
        for (int i = 0; i < 8; i++)
        begin
            init_v = random_p();
            init_v[`ACC_P_W-1] = 1'b1;              // Top slice never zero
            apply_cycle(1'b1, 1'b1, ACC_ADD, random_z(), init_v);
            check_value(init_v, "reload value not on p");
        end
        finish_test("reload", start);
    endtask

    task automatic random_sequence();
        int start;
        start = errors;
        for (int i = 0; i < RANDOM_CYCLES; i++)
        begin
            apply_cycle($urandom_range(0, 3) != 0, $urandom_range(0, 31) == 0,
                        ($urandom_range(0, 1) == 0) ? ACC_ADD : ACC_SUB,
                        random_z(), random_p());
        end
        finish_test("random add and subtract", start);
    endtask

    task automatic carry_and_borrow();
        int                  start;
        logic [`ACC_P_W-1:0] init_v;
        logic [`ACC_P_W-1:0] exp;
        logic [`ACC_Z_W-1:0] one_z;
        start = errors;
        one_z = '0;
        one_z[0] = 1'b1;
        init_v = '0;
        init_v[`ACC_SLICE_W-1:0] = '1;              // Slice 0 full
        apply_cycle(1'b1, 1'b1, ACC_ADD, one_z, init_v);
        apply_cycle(1'b1, 1'b0, ACC_ADD, one_z, init_v);
        exp = '0;
        exp[`ACC_SLICE_W] = 1'b1;
        check_value(exp, "carry did not reach slice 1");
        init_v = '0;
        init_v[`ACC_SLICE_W] = 1'b1;                // Slice 0 empty
        apply_cycle(1'b1, 1'b1, ACC_ADD, one_z, init_v);
        apply_cycle(1'b1, 1'b0, ACC_SUB, one_z, init_v);
        exp = '0;
        exp[`ACC_SLICE_W-1:0] = '1;
        check_value(exp, "borrow did not reach slice 1");
        finish_test("carry across slices", start);
    endtask

    task automatic extension_of_z();
        int                  start;
        logic [`ACC_Z_W-1:0] z_v;
        logic [`ACC_P_W-1:0] exp;
        start = errors;
        for (int i = 0; i < 4; i++)
        begin
            z_v = random_z();
            z_v[`ACC_Z_W-1] = 1'b1;
            apply_cycle(1'b1, 1'b1, ACC_ADD, z_v, '0);
            apply_cycle(1'b1, 1'b0, ACC_ADD, z_v, '0);
            exp = '0;
            exp[`ACC_Z_W-1:0] = z_v;
            if (Z_SIGNED != 0)
            begin
                exp[`ACC_P_W-1:`ACC_Z_W] = '1;
            end
            check_value(exp, "z extended wrongly");
        end
        finish_test("extension of z", start);
    endtask

    task automatic full_width_wrap();
        int                  start;
        logic [`ACC_P_W-1:0] init_v;
        logic [`ACC_P_W-1:0] exp;
        logic [`ACC_Z_W-1:0] z_v;
        start = errors;
        init_v = '1;
        init_v[1:0] = 2'b01;                        // Maximum minus 2
        z_v = '0;
        z_v[2:0] = 3'd5;
        apply_cycle(1'b1, 1'b1, ACC_ADD, z_v, init_v);
        apply_cycle(1'b1, 1'b0, ACC_ADD, z_v, init_v);
        exp = '0;
        exp[1] = 1'b1;
        check_value(exp, "add did not wrap");
        z_v = '0;
        z_v[0] = 1'b1;
        apply_cycle(1'b1, 1'b1, ACC_ADD, z_v, '0);
        apply_cycle(1'b1, 1'b0, ACC_SUB, z_v, '0);
        check_value('1, "subtract below zero did not wrap");
        finish_test("wraparound", start);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial
    begin
        void'($urandom(SEED));
        clk          = 1'b0;
        rst          = 1'b1;
        ce           = 1'b0;
        z            = '0;
        acc_init     = '0;
        reload       = 1'b0;
        acc_addsub   = ACC_ADD;
        model        = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        timed_out    = 1'b0;

        repeat (2) @(negedge clk);                  // Two rising edges in reset
        rst = 1'b0;

        reset_and_idle();
        reload_values();
        random_sequence();
        carry_and_borrow();
        extension_of_z();
        full_width_wrap();

        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if ((tests_failed == 0) && !timed_out)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: wide_accum.f
+incdir+common
common/wide_accum_pkg.sv
accum/acc_operand_prep.sv
accum/acc_slice.sv
rtl/wide_accum.sv
sim/wide_accum_asserts.sv
sim/wide_accum_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator for signed and unsigned z.
set -e
set -o pipefail

cd "$(dirname "$0")"

run_one() {
    local zs="$1"
    local mdir="obj_dir_z${zs}"
    local log="sim_z${zs}.log"

    echo "=== Z_SIGNED=${zs} ==="
    verilator --binary --assert --timing \
        --top-module wide_accum_tb \
        -GZ_SIGNED="${zs}" \
        --Mdir "${mdir}" \
        -f wide_accum.f

    "./${mdir}/Vwide_accum_tb" | tee "${log}"

    if grep -q "Test FAILED" "${log}"; then
        echo "Simulation failed with Z_SIGNED=${zs}"
        exit 1
    fi
}

run_one 1
run_one 0

echo "Both configurations finished without failures"
